//--- hdl/addr_gen.sv
`timescale 1ns/1ps

module addr_gen import lsm_pkg::*; (
	input logic clk,
	input logic reset,
	control_word_if.exec cw,
	input word_t rdata_a,
	output word_t ea
);

	word_t base;
	word_t disp_ext;
	word_t sum;
	word_t addr_q;

	assign base = cw.read_gpr_a ? rdata_a : '0;
	assign disp_ext = {{(WORD_WIDTH - DISP_WIDTH){cw.disp[DISP_WIDTH-1]}}, cw.disp};
	assign sum = base + disp_ext;

	// running word address, loaded once and then stepped per completed word
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			addr_q <= '0;
		end else if (cw.ls_first_cycle) begin
			addr_q <= sum;
		end else if (cw.ls_multiple_inc) begin
			addr_q <= addr_q + ADDR_STEP;
		end
	end

	// the first word cannot wait for the register
	assign ea = cw.ls_first_cycle ? sum : addr_q;

	strobes_exclusive: assert property (
		@(posedge clk) disable iff (reset) !(cw.ls_first_cycle && cw.ls_multiple_inc)
	);

endmodule

//--- hdl/control_word_if.sv
`timescale 1ns/1ps

interface control_word_if import lsm_pkg::*; ();

	logic ls_en;
	logic ls_we;
	// address register loads from the adder
	logic ls_first_cycle;
	// address register steps to the next word
	logic ls_multiple_inc;
	logic read_gpr_a;
	reg_index_t gpr_a;
	reg_index_t gpr_c;
	// load write-back target and its enable
	reg_index_t gpr_from_mem;
	logic write_gpr_from_mem;
	disp_t disp;

	modport decode (
		output ls_en,
		output ls_we,
		output ls_first_cycle,
		output ls_multiple_inc,
		output read_gpr_a,
		output gpr_a,
		output gpr_c,
		output gpr_from_mem,
		output write_gpr_from_mem,
		output disp
	);

	modport exec (
		input ls_first_cycle,
		input ls_multiple_inc,
		input read_gpr_a,
		input disp
	);

	modport mem (
		input ls_en,
		input ls_we,
		input gpr_from_mem,
		input write_gpr_from_mem
	);

endinterface

//--- hdl/decode_if.sv
`timescale 1ns/1ps

interface decode_if import lsm_pkg::*; ();

	// instruction word held by fetch while fetch_hold is high
	inst_t inst;
	// pipeline stall level
	logic hold;

	modport decode (
		input inst,
		input hold
	);

	modport source (
		output inst,
		output hold
	);

endinterface

//--- hdl/gpr_file.sv
`timescale 1ns/1ps

module gpr_file import lsm_pkg::*; (
	input logic clk,
	input logic reset,
	input reg_index_t ra_index,
	output word_t rdata_a,
	input reg_index_t rc_index,
	output word_t rdata_c,
	input logic we,
	input reg_index_t wa,
	input word_t wdata
);

	word_t regs [NUM_GPRS];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_GPRS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wa] <= wdata;
		end
	end

	// write-through so a same-cycle read sees the new value
	always_comb begin
		if (we && (wa == ra_index))
			rdata_a = wdata;
		else
			rdata_a = regs[ra_index];
	end

	always_comb begin
		if (we && (wa == rc_index))
			rdata_c = wdata;
		else
			rdata_c = regs[rc_index];
	end

endmodule

//--- hdl/lsm_core.sv
`timescale 1ns/1ps

module lsm_core import lsm_pkg::*; (
	input logic clk,
	input logic reset,
	input inst_t inst,
	input logic stall,
	output logic fetch_hold,
	output logic mem_en,
	output logic mem_we,
	output word_t mem_addr,
	output word_t mem_wdata,
	input word_t mem_rdata
);

	word_t rdata_a;
	word_t rdata_c;
	word_t ea;
	logic gpr_we;
	reg_index_t gpr_wa;
	word_t gpr_wdata;

	decode_if dec ();
	control_word_if cw ();

	assign dec.inst = inst;
	assign dec.hold = stall;

	lsm_decode u_decode (
		.clk(clk),
		.reset(reset),
		.dec(dec),
		.cw(cw),
		.fetch_hold(fetch_hold)
	);

	gpr_file u_gpr (
		.clk(clk),
		.reset(reset),
		.ra_index(cw.gpr_a),
		.rdata_a(rdata_a),
		.rc_index(cw.gpr_c),
		.rdata_c(rdata_c),
		.we(gpr_we),
		.wa(gpr_wa),
		.wdata(gpr_wdata)
	);

	addr_gen u_addr_gen (
		.clk(clk),
		.reset(reset),
		.cw(cw),
		.rdata_a(rdata_a),
		.ea(ea)
	);

	mem_access u_mem (
		.clk(clk),
		.reset(reset),
		.cw(cw),
		.ea(ea),
		.rdata_c(rdata_c),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.gpr_we(gpr_we),
		.gpr_wa(gpr_wa),
		.gpr_wdata(gpr_wdata)
	);

endmodule

//--- hdl/lsm_decode.sv
`timescale 1ns/1ps

module lsm_decode import lsm_pkg::*; (
	input logic clk,
	input logic reset,
	decode_if.decode dec,
	control_word_if.decode cw,
	output logic fetch_hold
);

	opcode_t opcode;
	reg_index_t rt;
	reg_index_t ra;
	logic is_lmw;
	logic is_stmw;
	logic active;
	logic seq_busy;
	logic word_done;
	lsm_state_t state;
	lsm_state_t next_state;
	reg_index_t target_ctr;
	reg_index_t next_target_ctr;
	reg_index_t target;
	ls_cycle_counter_t ls_ctr;
	ls_cycle_counter_t next_ls_ctr;

	assign opcode = inst_opcode(dec.inst);
	assign rt = inst_rt(dec.inst);
	assign ra = inst_ra(dec.inst);

	assign is_lmw = (opcode == OP_LMW);
	assign is_stmw = (opcode == OP_STMW);
	assign active = is_lmw || is_stmw;

	// words move in idle and count, finish and abort only release fetch
	assign seq_busy = active && ((state == S_IDLE) || (state == S_COUNT));
	assign word_done = seq_busy && (ls_ctr == '0) && !dec.hold;

	// first word targets rt, later words the running counter
	assign target = (state == S_IDLE) ? rt : target_ctr;

	// low for exactly one unstalled cycle at the end of a sequence
	assign fetch_hold = active && ((state == S_IDLE) || (state == S_COUNT) || dec.hold);

	always_comb begin
		cw.ls_en = 1'b0;
		cw.ls_we = 1'b0;
		cw.ls_first_cycle = 1'b0;
		cw.ls_multiple_inc = 1'b0;
		cw.read_gpr_a = 1'b0;
		cw.gpr_a = '0;
		cw.gpr_c = '0;
		cw.gpr_from_mem = '0;
		cw.write_gpr_from_mem = 1'b0;
		cw.disp = '0;
		if (active) begin
			cw.ls_en = seq_busy;
			cw.ls_we = seq_busy && is_stmw;
			cw.ls_first_cycle = seq_busy && (state == S_IDLE) &&
				(ls_ctr == LOAD_STORE_CYCLES);
			cw.ls_multiple_inc = word_done;
			// ra of zero means a literal zero base
			cw.read_gpr_a = (ra != '0);
			cw.gpr_a = ra;
			cw.gpr_c = target;
			cw.gpr_from_mem = target;
			cw.write_gpr_from_mem = seq_busy && is_lmw;
			cw.disp = inst_disp(dec.inst);
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				// rt of 31 has nothing left after the first word
				if (word_done)
					next_state = (rt == LAST_GPR) ? S_ABORT : S_COUNT;
			end
			S_COUNT: begin
				if (word_done && (target_ctr == LAST_GPR))
					next_state = S_FINISH;
			end
			S_FINISH, S_ABORT: begin
				if (!dec.hold)
					next_state = S_IDLE;
			end
			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

	always_comb begin
		next_target_ctr = target_ctr;
		if (word_done)
			next_target_ctr = target + reg_index_t'(1);
	end

	// the word counter runs on through stalls
	always_comb begin
		if (!seq_busy || (ls_ctr == '0))
			next_ls_ctr = LOAD_STORE_CYCLES;
		else
			next_ls_ctr = ls_ctr - ls_cycle_counter_t'(1);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= S_IDLE;
			target_ctr <= '0;
			ls_ctr <= LOAD_STORE_CYCLES;
		end else begin
			state <= next_state;
			target_ctr <= next_target_ctr;
			ls_ctr <= next_ls_ctr;
		end
	end

	state_onehot: assert property (
		@(posedge clk) disable iff (reset) $onehot(state)
	);

	// a load write-back and a store never share a word
	load_not_store: assert property (
		@(posedge clk) disable iff (reset) cw.write_gpr_from_mem |-> !cw.ls_we
	);

endmodule

//--- hdl/lsm_pkg.sv
package lsm_pkg;

	localparam int WORD_WIDTH = 32;
	localparam int INST_WIDTH = 32;
	localparam int REG_INDEX_WIDTH = 5;
	localparam int OPCODE_WIDTH = 6;
	localparam int DISP_WIDTH = 16;
	localparam int NUM_GPRS = 32;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [INST_WIDTH-1:0] inst_t;
	typedef logic [REG_INDEX_WIDTH-1:0] reg_index_t;
	typedef logic [OPCODE_WIDTH-1:0] opcode_t;
	typedef logic [DISP_WIDTH-1:0] disp_t;
	typedef logic [1:0] ls_cycle_counter_t;

	localparam opcode_t OP_LMW = 6'd46;
	localparam opcode_t OP_STMW = 6'd47;

	// reload value of the word-period down-counter
	localparam ls_cycle_counter_t LOAD_STORE_CYCLES = 2'd1;
	localparam word_t ADDR_STEP = 32'd4;
	localparam reg_index_t LAST_GPR = 5'd31;

	typedef enum logic [3:0] {
		S_IDLE   = 4'b0001,
		S_COUNT  = 4'b0010,
		S_FINISH = 4'b0100,
		S_ABORT  = 4'b1000
	} lsm_state_t;

	// D-form fields, bit 0 is the msb in the architecture numbering
	function automatic opcode_t inst_opcode(input inst_t inst);
		return inst[31:26];
	endfunction

	function automatic reg_index_t inst_rt(input inst_t inst);
		return inst[25:21];
	endfunction

	function automatic reg_index_t inst_ra(input inst_t inst);
		return inst[20:16];
	endfunction

	function automatic disp_t inst_disp(input inst_t inst);
		return inst[15:0];
	endfunction

endpackage

//--- hdl/mem_access.sv
`timescale 1ns/1ps

module mem_access import lsm_pkg::*; (
	input logic clk,
	input logic reset,
	control_word_if.mem cw,
	input word_t ea,
	input word_t rdata_c,
	output logic mem_en,
	output logic mem_we,
	output word_t mem_addr,
	output word_t mem_wdata,
	input word_t mem_rdata,
	output logic gpr_we,
	output reg_index_t gpr_wa,
	output word_t gpr_wdata
);

	ls_cycle_counter_t period_ctr;
	logic start;
	logic load_pending;
	reg_index_t load_target;

	// tracks the decode word counter and restarts whenever ls_en drops
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			period_ctr <= LOAD_STORE_CYCLES;
		else if (!cw.ls_en || (period_ctr == '0))
			period_ctr <= LOAD_STORE_CYCLES;
		else
			period_ctr <= period_ctr - ls_cycle_counter_t'(1);
	end

	assign start = cw.ls_en && (period_ctr == LOAD_STORE_CYCLES);

	assign mem_en = start;
	assign mem_we = start && cw.ls_we;
	assign mem_addr = ea;
	assign mem_wdata = rdata_c;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			load_pending <= 1'b0;
		else
			load_pending <= start && !cw.ls_we && cw.write_gpr_from_mem;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			load_target <= '0;
		else if (start)
			load_target <= cw.gpr_from_mem;
	end

	// read data arrives one clock after mem_en
	assign gpr_we = load_pending;
	assign gpr_wa = load_target;
	assign gpr_wdata = mem_rdata;

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the lsm_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module lsm_core_tb -o lsm_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/lsm_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test OK" "$LOG"; then
	exit 0
fi
exit 1

//--- src.f
hdl/lsm_pkg.sv
hdl/decode_if.sv
hdl/control_word_if.sv
hdl/lsm_decode.sv
hdl/gpr_file.sv
hdl/addr_gen.sv
hdl/mem_access.sv
hdl/lsm_core.sv
verification/lsm_core_tb.sv

//--- verification/lsm_core_tb.sv
`timescale 1ns/1ps

module lsm_core_tb import lsm_pkg::*; ();

	localparam int RESET_CYCLES = 10;
	localparam int TOTAL_WORDS = 50;
	localparam int WORD_PERIOD = int'(LOAD_STORE_CYCLES) + 1;
	localparam int STALL_BUDGET = 48;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + TOTAL_WORDS * WORD_PERIOD * 4 + STALL_BUDGET;
	// addi r3,r4,16 which this core treats as a no-op
	localparam inst_t NOP_INST = 32'h3864_0010;

	logic clk;
	logic reset;
	inst_t inst;
	logic stall;
	logic fetch_hold;
	logic mem_en;
	logic mem_we;
	word_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata = '0;

	word_t mem [word_t];
	word_t model_regs [32];
	word_t exp_addr [$];
	logic exp_we [$];
	word_t exp_data [$];
	logic pend_valid = 1'b0;
	logic pend_we = 1'b0;
	word_t pend_addr = '0;
	word_t pend_data = '0;
	word_t next_rdata = '0;
	int issued = 0;
	int completed = 0;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int test_start_errors = 0;
	int stall_left = 0;
	int stall_used = 0;

	lsm_core UUT (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.stall(stall),
		.fetch_hold(fetch_hold),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic inst_t encode(input opcode_t op, input reg_index_t rt,
		input reg_index_t ra, input disp_t disp);
		return {op, rt, ra, disp};
	endfunction

	// untouched locations return a pattern of their own address
	function automatic word_t mem_read(input word_t addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr ^ 32'hc3a5_5a3c;
	endfunction

	// expected word list for lmw/stmw and the matching register copy update
	function automatic void expect_sequence(input logic store, input reg_index_t rt,
		input reg_index_t ra, input disp_t disp);
		word_t addr;
		addr = ((ra == 5'd0) ? 32'd0 : model_regs[ra]) + {{16{disp[15]}}, disp};
		for (int r = int'(rt); r < 32; r++) begin
			exp_addr.push_back(addr);
			exp_we.push_back(store);
			if (store) begin
				exp_data.push_back(model_regs[r]);
			end else begin
				exp_data.push_back(mem_read(addr));
				model_regs[r] = mem_read(addr);
			end
			addr = addr + 32'd4;
		end
	endfunction

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	task automatic complete_access(input word_t addr, input logic we, input word_t data);
		word_t exp_word;
		completed++;
		if (exp_addr.size() == 0) begin
			$display("%0t: memory access to %h completed when none was expected", $time, addr);
			errors++;
		end else begin
			check_value("mem_addr", addr, exp_addr.pop_front());
			check_value("mem_we", word_t'(we), word_t'(exp_we.pop_front()));
			exp_word = exp_data.pop_front();
			if (we)
				check_value("mem_wdata", data, exp_word);
		end
	endtask

	// an access completes when stall is low in the clock after mem_en
	always @(negedge clk) begin
		if (!reset) begin
			if (pend_valid && !stall)
				complete_access(pend_addr, pend_we, pend_data);
			pend_valid = mem_en;
			pend_we = mem_we;
			pend_addr = mem_addr;
			if (mem_en) begin
				issued++;
				if (mem_we) begin
					mem[mem_addr] = mem_wdata;
					pend_data = mem_wdata;
				end else begin
					pend_data = mem_read(mem_addr);
					next_rdata = pend_data;
				end
			end
		end
	end

	always @(posedge clk) begin
		#1;
		mem_rdata = next_rdata;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles waiting for fetch_hold to fall", cycles);
		$display("Test FAILED");
		$finish;
	end

	task automatic drive_stall();
		if (stall_left == 0 && ($urandom % 4) == 0)
			stall_left = 1 + int'($urandom % 3);
		if (stall_left > 0 && stall_used < STALL_BUDGET) begin
			stall = 1'b1;
			stall_left--;
			stall_used++;
		end else begin
			stall = 1'b0;
		end
	endtask

	// hold the instruction until fetch_hold falls and then idle on a no-op
	task automatic run_inst(input inst_t ins, input logic use_stall);
		logic released;
		released = 1'b0;
		@(posedge clk);
		#1;
		inst = ins;
		stall = 1'b0;
		while (!released) begin
			@(negedge clk);
			if (!fetch_hold) begin
				released = 1'b1;
			end else begin
				@(posedge clk);
				#1;
				if (use_stall)
					drive_stall();
			end
		end
		@(posedge clk);
		#1;
		inst = NOP_INST;
		stall = 1'b0;
		if (exp_addr.size() != 0) begin
			$display("%0t: %0d words had not completed when fetch_hold fell", $time,
				exp_addr.size());
			errors++;
			exp_addr.delete();
			exp_we.delete();
			exp_data.delete();
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic end_test(input string name);
		if (errors == test_start_errors) begin
			tests_passed++;
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: fail with %0d errors", name, errors - test_start_errors);
		end
		test_start_errors = errors;
	endtask

	initial begin
		int words_before;
		void'($urandom(32'h98f0_c7c7));
		reset = 1'b1;
		inst = NOP_INST;
		stall = 1'b0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		@(negedge clk);
		check_value("fetch_hold", word_t'(fetch_hold), '0);
		check_value("mem_en", word_t'(mem_en), '0);
		check_value("mem_we", word_t'(mem_we), '0);
		run_inst(NOP_INST, 1'b0);
		check_value("access count", word_t'(issued), '0);
		end_test("reset and other opcode");

		// r20 picks up 0x1000 as the base for the later tests
		mem[32'hffff_ff00] = 32'h0000_1000;
		expect_sequence(1'b0, 5'd20, 5'd0, 16'hff00);
		run_inst(encode(OP_LMW, 5'd20, 5'd0, 16'hff00), 1'b0);
		expect_sequence(1'b1, 5'd20, 5'd0, 16'hff80);
		run_inst(encode(OP_STMW, 5'd20, 5'd0, 16'hff80), 1'b0);
		end_test("ra zero with negative displacement");

		for (int k = 0; k < 6; k++)
			mem[32'h0000_1040 + word_t'(k * 4)] = $urandom;
		expect_sequence(1'b0, 5'd26, 5'd20, 16'h0040);
		run_inst(encode(OP_LMW, 5'd26, 5'd20, 16'h0040), 1'b0);
		expect_sequence(1'b1, 5'd26, 5'd20, 16'h0200);
		run_inst(encode(OP_STMW, 5'd26, 5'd20, 16'h0200), 1'b0);
		end_test("lmw then stmw of six words");

		words_before = completed;
		expect_sequence(1'b0, 5'd31, 5'd20, 16'h0010);
		run_inst(encode(OP_LMW, 5'd31, 5'd20, 16'h0010), 1'b0);
		expect_sequence(1'b1, 5'd31, 5'd20, 16'h0300);
		run_inst(encode(OP_STMW, 5'd31, 5'd20, 16'h0300), 1'b0);
		check_value("completed words", word_t'(completed - words_before), 32'd2);
		end_test("rt 31 single word");

		expect_sequence(1'b1, 5'd20, 5'd20, 16'h0400);
		run_inst(encode(OP_STMW, 5'd20, 5'd20, 16'h0400), 1'b1);
		if (stall_used == 0) begin
			$display("no stall cycle was applied during the stalled store");
			errors++;
		end
		end_test("stmw under random stall");

		$display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
